//--- filelist.f
+incdir+sim
src/threat_pkg.sv
src/window_scanner.sv
src/open_two_matcher.sv
src/point_queue.sv
src/threat_finder.sv
sim/threat_finder_tb.sv

//--- sim/threat_ref.svh
`ifndef THREAT_REF_SVH
`define THREAT_REF_SVH

// each expected point packs {row, col} and the list follows the scan order
typedef logic [7:0] pt_list_t [$];

function automatic pt_list_t threat_ref(input board_t board, input cell_t colour);
    pt_list_t pts;
    cell_t    w [6];
    int       dr;
    int       dc;
    int       c_first;
    int       r_last;
    int       c_last;
    int       n_stone;
    int       n_empty;
    for (int d = 0; d < 4; d++) begin
        // cell step and the range of start cells for each direction
        dr      = (d == 1) ? 0 : 1;
        dc      = (d == 0) ? 0 : ((d == 3) ? -1 : 1);
        c_first = (d == 3) ? 5 : 0;
        r_last  = (d == 1) ? BOARD_DIM - 1 : 9;
        c_last  = (d == 1 || d == 2) ? 9 : BOARD_DIM - 1;
        for (int r = 0; r <= r_last; r++) begin
            for (int c = c_first; c <= c_last; c++) begin
                n_stone = 0;
                n_empty = 0;
                for (int k = 0; k < 6; k++) begin
                    w[k] = board[(r + k * dr) * BOARD_DIM + c + k * dc];
                end
                for (int k = 1; k < 5; k++) begin
                    n_stone += (w[k] == colour) ? 1 : 0;
                    n_empty += (w[k] == CELL_EMPTY) ? 1 : 0;
                end
                if (w[0] == CELL_EMPTY && w[5] == CELL_EMPTY &&
                    n_stone == 2 && n_empty == 2) begin
                    // the gaps are reported from the start of the window on
                    for (int k = 1; k < 5; k++) begin
                        if (w[k] == CELL_EMPTY) begin
                            pts.push_back({4'(r + k * dr), 4'(c + k * dc)});
                        end
                    end
                end
            end
        end
    end
    return pts;
endfunction

`endif

//--- sim/threat_finder_tb.sv
`timescale 1ns/1ps

module threat_finder_tb;

    import threat_pkg::*;

    `include "threat_ref.svh"

    localparam int QUEUE_DEPTH = 8;
    localparam int OUT_CREDITS = 4;
    localparam int TIMEOUT     = 40000;

    logic     i_clk;
    logic     i_rst_n;
    logic     i_start;
    logic     i_turn;
    logic     i_defend;
    board_t   i_board;
    logic     i_credit_return;
    logic     o_pt_valid;
    coord_t   o_pt_row;
    coord_t   o_pt_col;
    count_t   o_size;
    logic     o_finish;

    pt_list_t exp_pts;
    board_t   boards [8];
    logic     turns [8];
    int       got = 0;
    int       owed = 0;
    int       finish_cnt = 0;
    int       size_at_finish = 0;
    int       max_delay = 0;
    int       test_err = 0;
    int       n_tests = 0;
    int       n_failed = 0;
    int       n_errors = 0;

    threat_finder #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) i_threat_finder (.*);

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // outputs settle well before the falling edge
    always @(negedge i_clk) begin
        if (i_rst_n && o_pt_valid) begin
            if (got < exp_pts.size()) begin
                assert (o_pt_row == exp_pts[got][7:4]) else begin
                    $display("MISMATCH at %0t: o_pt_row expected %0d got %0d",
                             $time, exp_pts[got][7:4], o_pt_row);
                    test_err++;
                end
                assert (o_pt_col == exp_pts[got][3:0]) else begin
                    $display("MISMATCH at %0t: o_pt_col expected %0d got %0d",
                             $time, exp_pts[got][3:0], o_pt_col);
                    test_err++;
                end
            end else begin
                $display("ERROR at %0t: point beyond the %0d expected", $time, exp_pts.size());
                test_err++;
            end
            got++;
            owed++;
            assert (owed <= OUT_CREDITS) else begin
                $display("ERROR at %0t: %0d beats outstanding with only %0d credits",
                         $time, owed, OUT_CREDITS);
                test_err++;
            end
        end
        if (i_rst_n && o_finish) begin
            finish_cnt++;
            size_at_finish = o_size;
        end
    end

    // the sink hands one credit back per pulse, after a random gap
    initial begin
        int gap;
        gap             = 0;
        i_credit_return = 1'b0;
        forever begin
            @(posedge i_clk);
            #1;
            if (owed > 0 && gap == 0) begin
                i_credit_return = 1'b1;
                owed--;
                gap = $urandom_range(max_delay, 0);
            end else begin
                i_credit_return = 1'b0;
                if (gap > 0) begin
                    gap--;
                end
            end
        end
    end

    // about a fifth of the cells per colour
    function automatic board_t random_board();
        board_t b;
        int     r;
        for (int i = 0; i < BOARD_CELLS; i++) begin
            r    = $urandom_range(99, 0);
            b[i] = (r < 20) ? CELL_BLACK : ((r < 40) ? CELL_WHITE : CELL_EMPTY);
        end
        return b;
    endfunction

    task automatic run_search(input string name, input board_t board, input logic turn,
                              input logic defend, input logic mid_start);
        int    cyc;
        cell_t mover;
        cell_t foe;
        // turn 0 means black is to move
        mover      = turn ? CELL_WHITE : CELL_BLACK;
        foe        = turn ? CELL_BLACK : CELL_WHITE;
        // attack looks for the side to move, defend for the opponent
        exp_pts    = threat_ref(board, defend ? foe : mover);
        got        = 0;
        finish_cnt = 0;
        test_err   = 0;
        @(posedge i_clk);
        #1;
        i_board  = board;
        i_turn   = turn;
        i_defend = defend;
        i_start  = 1'b1;
        cyc      = 0;
        while (finish_cnt == 0 && cyc < TIMEOUT) begin
            @(posedge i_clk);
            #1;
            cyc++;
            i_start = mid_start && (cyc == 200);
        end
        // a few more cycles to catch a second finish
        repeat (20) @(posedge i_clk);
        assert (finish_cnt == 1) else begin
            $display("ERROR: %s saw %0d finish pulses instead of one", name, finish_cnt);
            test_err++;
        end
        assert (got == exp_pts.size()) else begin
            $display("ERROR: %s sent %0d points, expected %0d", name, got, exp_pts.size());
            test_err++;
        end
        assert (finish_cnt == 0 || size_at_finish == exp_pts.size()) else begin
            $display("MISMATCH at %0t: o_size expected %0d got %0d",
                     $time, exp_pts.size(), size_at_finish);
            test_err++;
        end
        cyc = 0;
        while (owed > 0 && cyc < TIMEOUT) begin
            @(posedge i_clk);
            cyc++;
        end
        assert (owed == 0) else begin
            $display("ERROR: %s left %0d credits unreturned", name, owed);
            test_err++;
        end
        n_tests++;
        n_errors += test_err;
        if (test_err > 0) begin
            n_failed++;
        end
        $display("%-20s %4d points  %s", name, exp_pts.size(), (test_err > 0) ? "failed" : "ok");
    endtask

    initial begin
        board_t b;
        void'($urandom(43606));
        i_rst_n  = 1'b0;
        i_start  = 1'b0;
        i_turn   = 1'b0;
        i_defend = 1'b0;
        i_board  = {BOARD_CELLS{CELL_EMPTY}};
        repeat (16) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;

        b = {BOARD_CELLS{CELL_EMPTY}};
        run_search("empty board", b, 1'b0, 1'b0, 1'b0);
        b[7 * BOARD_DIM + 5] = CELL_BLACK;
        b[7 * BOARD_DIM + 6] = CELL_BLACK;
        run_search("horizontal two", b, 1'b0, 1'b0, 1'b0);

        for (int n = 0; n < 8; n++) begin
            boards[n] = random_board();
            turns[n]  = 1'($urandom_range(1, 0));
            run_search($sformatf("random attack %0d", n), boards[n], turns[n], 1'b0, 1'b0);
        end
        for (int n = 0; n < 8; n++) begin
            run_search($sformatf("random defend %0d", n), boards[n], turns[n], 1'b1, 1'b0);
        end

        max_delay = 20;
        for (int n = 0; n < 3; n++) begin
            run_search($sformatf("credit stall %0d", n), boards[n], turns[n], 1'b0, 1'b0);
        end
        max_delay = 0;
        run_search("start while busy", boards[3], turns[3], 1'b0, 1'b1);

        $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, n_errors);
        if (n_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- src/open_two_matcher.sv
`timescale 1ns/1ps

module open_two_matcher (
    input  threat_pkg::window_t i_window,
    input  threat_pkg::cell_t   i_colour,
    output logic                o_match,
    output logic [1:0]          o_sel_a,
    output logic [1:0]          o_sel_b
);

    import threat_pkg::*;

    logic [2:0] n_stone;
    logic [2:0] n_empty;
    logic       found_a;
    logic       ends_open;
    logic       colour_ok;

    assign ends_open = (i_window[0] == CELL_EMPTY) && (i_window[WIN_LEN-1] == CELL_EMPTY);
    assign colour_ok = (i_colour == CELL_BLACK) || (i_colour == CELL_WHITE);

    // count the inner cells and pick out the first and last empty one
    always_comb begin
        n_stone = '0;
        n_empty = '0;
        found_a = 1'b0;
        o_sel_a = '0;
        o_sel_b = '0;
        for (int k = 1; k <= 4; k++) begin
            if (i_window[k] == i_colour) begin
                n_stone = n_stone + 1'b1;
            end
            if (i_window[k] == CELL_EMPTY) begin
                n_empty = n_empty + 1'b1;
                if (!found_a) begin
                    o_sel_a = 2'(k - 1);
                    found_a = 1'b1;
                end
                o_sel_b = 2'(k - 1);
            end
        end
    end

    // two stones and two gaps inside open ends covers the joined and split twos
    assign o_match = colour_ok && ends_open && (n_stone == 3'd2) && (n_empty == 3'd2);

    always_comb begin
        if (o_match) begin
            a_sel_differ : assert (o_sel_a != o_sel_b)
                else $error("open two reported the same point twice");
        end
    end

endmodule

//--- src/point_queue.sv
`timescale 1ns/1ps

module point_queue #(
    parameter int QUEUE_DEPTH = 8,
    parameter int OUT_CREDITS = 4
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_start,
    input  logic               i_push2,
    input  threat_pkg::coord_t i_row_a,
    input  threat_pkg::coord_t i_col_a,
    input  threat_pkg::coord_t i_row_b,
    input  threat_pkg::coord_t i_col_b,
    input  logic               i_credit_return,
    output logic               o_room,
    output logic               o_empty,
    output logic               o_pt_valid,
    output threat_pkg::coord_t o_pt_row,
    output threat_pkg::coord_t o_pt_col,
    output threat_pkg::count_t o_size
);

    import threat_pkg::*;

    localparam int PTR_W  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int FILL_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CRED_W = $clog2(OUT_CREDITS + 2);

    coord_t            mem_row [QUEUE_DEPTH];
    coord_t            mem_col [QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  wr_ptr_b;
    logic [PTR_W-1:0]  rd_ptr;
    logic [FILL_W-1:0] fill;
    logic [FILL_W-1:0] fill_nxt;
    logic [CRED_W-1:0] credits;
    logic              pop;

    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
        return (int'(p) == QUEUE_DEPTH - 1) ? '0 : p + 1'b1;
    endfunction

    assign wr_ptr_b = ptr_inc(wr_ptr);
    assign o_empty  = (fill == '0);
    assign pop      = !o_empty && (credits != '0);
    assign fill_nxt = fill + (i_push2 ? FILL_W'(2) : FILL_W'(0)) - FILL_W'(pop);

    // room must cover a pair that is already on its way from the scanner
    assign o_room = (int'(fill_nxt) + 2 <= QUEUE_DEPTH);

    assign o_pt_valid = pop;
    assign o_pt_row   = mem_row[rd_ptr];
    assign o_pt_col   = mem_col[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (i_push2) begin
            mem_row[wr_ptr]   <= i_row_a;
            mem_col[wr_ptr]   <= i_col_a;
            mem_row[wr_ptr_b] <= i_row_b;
            mem_col[wr_ptr_b] <= i_col_b;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
            credits <= CRED_W'(OUT_CREDITS);
            o_size  <= '0;
        end else begin
            if (i_push2) begin
                wr_ptr <= ptr_inc(wr_ptr_b);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            fill    <= fill_nxt;
            credits <= credits - CRED_W'(pop) + CRED_W'(i_credit_return);
            if (i_start) begin
                o_size <= '0;
            end else if (pop) begin
                o_size <= o_size + 1'b1;
            end
        end
    end

    // the scanner must only step when the pair it produces will fit
    a_no_overflow : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_push2 |-> int'(fill) - int'(pop) + 2 <= QUEUE_DEPTH)
        else $error("point queue overflow");

    a_credit_limit : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        credits <= OUT_CREDITS)
        else $error("sink returned more credits than it was given");

endmodule

//--- src/threat_finder.sv
`timescale 1ns/1ps

module threat_finder #(
    parameter int QUEUE_DEPTH = 8,
    parameter int OUT_CREDITS = 4
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_start,
    input  logic               i_turn,
    input  logic               i_defend,
    input  threat_pkg::board_t i_board,
    input  logic               i_credit_return,
    output logic               o_pt_valid,
    output threat_pkg::coord_t o_pt_row,
    output threat_pkg::coord_t o_pt_col,
    output threat_pkg::count_t o_size,
    output logic               o_finish
);

    import threat_pkg::*;

    logic       busy;
    logic       scan_done;
    logic       start_ok;
    cell_t      colour;
    logic       w_win_valid;
    window_t    w_window;
    coord_t     w_pt_row [4];
    coord_t     w_pt_col [4];
    logic       w_done;
    logic       w_match;
    logic [1:0] w_sel_a;
    logic [1:0] w_sel_b;
    logic       w_room;
    logic       w_empty;
    logic       w_push2;

    assign start_ok = i_start && !busy;
    assign w_push2  = w_win_valid && w_match;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy      <= 1'b0;
            scan_done <= 1'b0;
            o_finish  <= 1'b0;
        end else begin
            o_finish <= 1'b0;
            if (start_ok) begin
                busy      <= 1'b1;
                scan_done <= 1'b0;
            end else if (busy) begin
                if (w_done) begin
                    scan_done <= 1'b1;
                end
                // finish only once the queue has drained every point
                if (scan_done && w_empty) begin
                    busy     <= 1'b0;
                    o_finish <= 1'b1;
                end
            end
        end
    end

    // defend mode searches the opponent's stones
    always_ff @(posedge i_clk) begin
        if (start_ok) begin
            colour <= (i_turn ^ i_defend) ? CELL_WHITE : CELL_BLACK;
        end
    end

    window_scanner i_window_scanner (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (start_ok),
        .i_room      (w_room),
        .i_board     (i_board),
        .o_win_valid (w_win_valid),
        .o_window    (w_window),
        .o_pt_row    (w_pt_row),
        .o_pt_col    (w_pt_col),
        .o_done      (w_done)
    );

    open_two_matcher i_open_two_matcher (
        .i_window (w_window),
        .i_colour (colour),
        .o_match  (w_match),
        .o_sel_a  (w_sel_a),
        .o_sel_b  (w_sel_b)
    );

    point_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) i_point_queue (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (start_ok),
        .i_push2         (w_push2),
        .i_row_a         (w_pt_row[w_sel_a]),
        .i_col_a         (w_pt_col[w_sel_a]),
        .i_row_b         (w_pt_row[w_sel_b]),
        .i_col_b         (w_pt_col[w_sel_b]),
        .i_credit_return (i_credit_return),
        .o_room          (w_room),
        .o_empty         (w_empty),
        .o_pt_valid      (o_pt_valid),
        .o_pt_row        (o_pt_row),
        .o_pt_col        (o_pt_col),
        .o_size          (o_size)
    );

endmodule

//--- src/threat_pkg.sv
package threat_pkg;

    // board geometry
    localparam int BOARD_DIM   = 15;
    localparam int BOARD_CELLS = BOARD_DIM * BOARD_DIM;
    localparam int WIN_LEN     = 6;

    // last start position along a line for a full window
    localparam int LINE_LAST = BOARD_DIM - WIN_LEN;

    // code 3 of the cell encoding is unused and never matches a colour
    typedef logic [1:0] cell_t;

    localparam cell_t CELL_BLACK = 2'd0;
    localparam cell_t CELL_WHITE = 2'd1;
    localparam cell_t CELL_EMPTY = 2'd2;

    // a row or column index
    typedef logic [3:0] coord_t;

    // cell index is row * BOARD_DIM + column
    typedef cell_t [BOARD_CELLS-1:0] board_t;

    // cell k lies k steps from the window start
    typedef cell_t [WIN_LEN-1:0] window_t;

    // line direction
    typedef logic [1:0] dir_t;

    localparam dir_t DIR_VERT       = 2'd0;
    localparam dir_t DIR_HORZ       = 2'd1;
    localparam dir_t DIR_DOWN_RIGHT = 2'd2;
    localparam dir_t DIR_DOWN_LEFT  = 2'd3;

    // up to 500 windows with two points each
    typedef logic [9:0] count_t;

endpackage

//--- src/window_scanner.sv
`timescale 1ns/1ps

module window_scanner (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  logic                i_room,
    input  threat_pkg::board_t  i_board,
    output logic                o_win_valid,
    output threat_pkg::window_t o_window,
    output threat_pkg::coord_t  o_pt_row [4],
    output threat_pkg::coord_t  o_pt_col [4],
    output logic                o_done
);

    import threat_pkg::*;

    logic   busy;
    logic   step;
    logic   last_pos;
    logic   win_last;
    dir_t   dir;
    coord_t row;
    coord_t col;
    coord_t cell_row [WIN_LEN];
    coord_t cell_col [WIN_LEN];
    logic [7:0] cell_idx [WIN_LEN];

    // the down-left lines need five cells of room to the left
    function automatic coord_t col_lo(dir_t d);
        return (d == DIR_DOWN_LEFT) ? coord_t'(WIN_LEN - 1) : '0;
    endfunction

    function automatic coord_t col_hi(dir_t d);
        return (d == DIR_HORZ || d == DIR_DOWN_RIGHT) ? coord_t'(LINE_LAST) :
                                                        coord_t'(BOARD_DIM - 1);
    endfunction

    function automatic coord_t row_hi(dir_t d);
        return (d == DIR_HORZ) ? coord_t'(BOARD_DIM - 1) : coord_t'(LINE_LAST);
    endfunction

    assign step     = busy && i_room;
    assign last_pos = (dir == DIR_DOWN_LEFT) && (row == row_hi(dir)) && (col == col_hi(dir));

    // cell positions of the window that starts at (row, col)
    always_comb begin
        for (int k = 0; k < WIN_LEN; k++) begin
            cell_row[k] = (dir == DIR_HORZ) ? row : row + coord_t'(k);
            case (dir)
                DIR_VERT:      cell_col[k] = col;
                DIR_DOWN_LEFT: cell_col[k] = col - coord_t'(k);
                default:       cell_col[k] = col + coord_t'(k);
            endcase
            cell_idx[k] = 8'(cell_row[k] * BOARD_DIM + cell_col[k]);
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy        <= 1'b0;
            dir         <= DIR_VERT;
            row         <= '0;
            col         <= '0;
            win_last    <= 1'b0;
            o_win_valid <= 1'b0;
            o_done      <= 1'b0;
        end else begin
            o_win_valid <= step;
            // the last window has been matched and pushed by now
            o_done      <= o_win_valid && win_last;
            if (!busy) begin
                if (i_start) begin
                    busy <= 1'b1;
                    dir  <= DIR_VERT;
                    row  <= '0;
                    col  <= col_lo(DIR_VERT);
                end
            end else if (i_room) begin
                win_last <= last_pos;
                if (last_pos) begin
                    busy <= 1'b0;
                end else if (col != col_hi(dir)) begin
                    col <= col + 1'b1;
                end else if (row != row_hi(dir)) begin
                    row <= row + 1'b1;
                    col <= col_lo(dir);
                end else begin
                    dir <= dir + 1'b1;
                    row <= '0;
                    col <= col_lo(dir + 1'b1);
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (step) begin
            for (int k = 0; k < WIN_LEN; k++) begin
                o_window[k] <= i_board[cell_idx[k]];
            end
            // only the four inner cells can be reported
            for (int k = 1; k <= 4; k++) begin
                o_pt_row[k-1] <= cell_row[k];
                o_pt_col[k-1] <= cell_col[k];
            end
        end
    end

endmodule
